// ==== list.f ====
+incdir+include
rtl/iir_pkg.sv
rtl/iir_apb_regs.sv
rtl/triangle_osc.sv
rtl/biquad_mac.sv
rtl/iir_biquad_system.sv
tb/tb_iir_biquad_system.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_iir_biquad_system
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_iir_biquad_system.sv ====
//////////////////////////////////////////////////
// testbench for the biquad test system: APB setup,
// triangle and DF-I reference model, table of rows
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_params.svh"

module tb_iir_biquad_system
  import iir_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY  = 2;
  localparam int W          = `IIR_WAVE_WIDTH;
  localparam int N          = `IIR_N_BITS;
  localparam int C          = `IIR_COEF_WIDTH;
  localparam int AW         = `IIR_APB_ADDR_WIDTH;
  localparam int DW         = `IIR_APB_DATA_WIDTH;
  localparam int NROWS      = 7;
  localparam int WAVE_MAX   = 2**(W-1) - 1;
  localparam int WAVE_MIN   = -(2**(W-1));
  localparam int Y_MAX      = 2**(N-1) - 1;
  localparam int Y_MIN      = -(2**(N-1));

  // Q2.14 constants
  localparam logic signed [C-1:0] Q_ONE     = 16384;
  localparam logic signed [C-1:0] Q_QUARTER = 4096;
  localparam logic signed [C-1:0] Q_HALF    = 8192;
  localparam logic signed [C-1:0] Q_EIGHTH  = 2048;
  localparam logic signed [C-1:0] Q_199     = 32604;   // 1.99

  typedef struct packed {
    logic                                bypass;
    logic [W-1:0]                        step;
    logic [`IIR_MAX_PERIOD_WIDTH-1:0]    period;
    logic signed [C-1:0]                 b0;
    logic signed [C-1:0]                 b1;
    logic signed [C-1:0]                 b2;
    logic signed [C-1:0]                 a1;
    logic signed [C-1:0]                 a2;
    logic                                rand_coef;
    logic [15:0]                         count;
    logic                                exp_ovr;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [AW-1:0]       paddr;
  logic [DW-1:0]       pwdata;
  logic                pready;
  logic [DW-1:0]       prdata;
  logic                y_valid;
  logic signed [N-1:0] y;

  row_t                rows [NROWS];
  row_t                cur;
  int                  n_loaded;
  int                  n_checks;
  int                  n_errors;
  logic [31:0]         lfsr_state;
  logic signed [W-1:0] m_wave;        // reference triangle
  ramp_dir_t           m_dir;
  logic signed [N-1:0] m_x1;
  logic signed [N-1:0] m_x2;
  logic signed [N-1:0] m_y1;
  logic signed [N-1:0] m_y2;

  iir_biquad_system uut (
    .clk     ( clk     ), .rst_n   ( rst_n   ),
    .psel    ( psel    ), .penable ( penable ), .pwrite ( pwrite ),
    .paddr   ( paddr   ), .pwdata  ( pwdata  ),
    .pready  ( pready  ), .prdata  ( prdata  ),
    .y_valid ( y_valid ), .y       ( y       )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus table and random coefficients
  //////////////////////////////////////////////////

  task add_row(input logic bp, input int step, input int period,
               input logic signed [C-1:0] b0, input logic signed [C-1:0] b1,
               input logic signed [C-1:0] b2, input logic signed [C-1:0] a1,
               input logic signed [C-1:0] a2, input logic rnd, input int count,
               input logic ovr);
    rows[n_loaded] = '{bp, W'(step), 16'(period), b0, b1, b2, a1, a2, rnd, 16'(count), ovr};
    n_loaded++;
  endtask

  task fill_table;
    n_loaded = 0;
    add_row(0, 300, 8, Q_ONE, 0, 0, 0, 0, 0, 40, 0);             // identity, both clamps
    add_row(0, 200, 8, Q_QUARTER, Q_QUARTER, Q_QUARTER, -Q_HALF, Q_EIGHTH, 0, 40, 0);
    add_row(1, 500, 8, Q_QUARTER, Q_QUARTER, Q_QUARTER, -Q_HALF, Q_EIGHTH, 0, 30, 0);
    add_row(0, 150, 2, Q_QUARTER, Q_QUARTER, Q_QUARTER, -Q_HALF, Q_EIGHTH, 0, 20, 1);
    add_row(0, 250, 16, 0, 0, 0, 0, 0, 1, 20, 0);                // random taps
    add_row(0, 400, 8, Q_199, 0, 0, -Q_199, 0, 0, 20, 0);        // positive saturation
    add_row(0, 400, 8, -Q_199, 0, 0, -Q_199, 0, 0, 20, 0);       // negative saturation
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // 12-bit magnitude and a sign, stays within +-0.25
  function automatic logic signed [C-1:0] random_coef();
    logic [11:0] mag;
    logic        neg;
    mag = '0;
    for (int b = 0; b < 12; b++) begin
      mag        = {mag[10:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    neg        = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return neg ? -$signed({4'b0, mag}) : $signed({4'b0, mag});
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  task model_reset;
    m_wave = '0;
    m_dir  = UP;
    m_x1   = '0;
    m_x2   = '0;
    m_y1   = '0;
    m_y2   = '0;
  endtask

  task predict(output logic signed [N-1:0] exp);
    logic signed [N-1:0] x0;
    longint              acc;
    longint              sh;
    int                  nxt;
    x0 = m_wave;                                       // sign-extended sample
    if (m_dir == UP) begin
      nxt = int'(m_wave) + int'(cur.step);
      if (nxt > WAVE_MAX) begin
        m_wave = W'(WAVE_MAX);
        m_dir  = DOWN;
      end else
        m_wave = W'(nxt);
    end else begin
      nxt = int'(m_wave) - int'(cur.step);
      if (nxt < WAVE_MIN) begin
        m_wave = W'(WAVE_MIN);
        m_dir  = UP;
      end else
        m_wave = W'(nxt);
    end
    if (cur.bypass)
      exp = x0;
    else begin
      acc = longint'(cur.b0) * longint'(x0) + longint'(cur.b1) * longint'(m_x1)
          + longint'(cur.b2) * longint'(m_x2) - longint'(cur.a1) * longint'(m_y1)
          - longint'(cur.a2) * longint'(m_y2);
      sh = acc >>> `IIR_Q_BITS;                        // floor
      if (sh > Y_MAX)
        exp = N'(Y_MAX);
      else if (sh < Y_MIN)
        exp = N'(Y_MIN);
      else
        exp = N'(sh);
      m_x2 = m_x1;
      m_x1 = x0;
      m_y2 = m_y1;
      m_y1 = exp;
    end
  endtask

  //////////////////////////////////////////////////
  // APB driver and compare tasks
  //////////////////////////////////////////////////

  // access phase ends on the first edge that sees pready
  task wait_ready;
    int waits;
    waits = 0;
    @(negedge clk);
    while (!pready && waits < 8) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      n_errors++;
      $display("APB slave never raised pready, transfer to address %0h abandoned", paddr);
    end
  endtask

  task apb_write(input reg_addr_t addr, input logic [DW-1:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
    wait_ready();
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task apb_read(input reg_addr_t addr, output logic [DW-1:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
    wait_ready();
    data = prdata;                                     // mid access phase
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task check_sample(input logic signed [N-1:0] got, input logic signed [N-1:0] exp,
                    input int idx);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0d ns: output %0d is %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task check_status(input logic got, input logic exp, input int r);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0d ns: row %0d overrun flag is %0b, expected %0b",
               $time, r, got, exp);
    end
  endtask

  task run_row(input int r);
    logic signed [N-1:0] exp;
    logic [DW-1:0]       st;
    int                  got_n;
    int                  idle;
    int                  limit;
    int                  err_before;
    err_before = n_errors;
    cur        = rows[r];
    if (cur.rand_coef) begin
      cur.b0 = random_coef();
      cur.b1 = random_coef();
      cur.b2 = random_coef();
      cur.a1 = random_coef();
      cur.a2 = random_coef();
    end
    model_reset();
    apb_write(STEP, DW'(cur.step));
    apb_write(PERIOD, DW'(cur.period));
    apb_write(B0, DW'(cur.b0));
    apb_write(B1, DW'(cur.b1));
    apb_write(B2, DW'(cur.b2));
    apb_write(A1, DW'(cur.a1));
    apb_write(A2, DW'(cur.a2));
    apb_write(CTRL, DW'({cur.bypass, 1'b1}));
    got_n = 0;
    idle  = 0;
    limit = 20 * int'(cur.period) + 100;              // cycles without output
    while (got_n < int'(cur.count) && idle < limit) begin
      @(negedge clk);
      if (y_valid) begin
        predict(exp);
        check_sample(y, exp, got_n);
        got_n++;
        idle = 0;
      end else
        idle++;
    end
    if (got_n < int'(cur.count)) begin
      n_errors++;
      $display("row %0d stalled, no output after %0d of %0d samples", r, got_n, cur.count);
    end
    apb_write(CTRL, '0);                               // stop, flush, restart wave
    apb_read(STATUS, st);
    check_status(st[0], cur.exp_ovr, r);
    apb_write(STATUS, '0);
    $display("row %0d: %0d outputs, %0d errors", r, got_n, n_errors - err_before);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    n_checks   = 0;
    n_errors   = 0;
    lfsr_state = 32'd77221;
    fill_table();
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    for (int r = 0; r < NROWS; r++)
      run_row(r);
    $display("done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial begin
    longint limit;
    #1;                                                // table is filled at time zero
    limit = 0;
    for (int r = 0; r < NROWS; r++)
      limit += (longint'(rows[r].count) + 4) * longint'(rows[r].period) * CLK_PERIOD;
    limit = 2 * limit + 2000;
    #(limit);
    $display("watchdog expired after %0d ns, simulation did not finish", limit);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== rtl/iir_biquad_system.sv ====
//////////////////////////////////////////////////
// biquad test system: APB registers, triangle
// source and filter stage
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_params.svh"

`default_nettype none

module iir_biquad_system (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 psel,
  input  wire                                 penable,
  input  wire                                 pwrite,
  input  wire        [`IIR_APB_ADDR_WIDTH-1:0] paddr,
  input  wire        [`IIR_APB_DATA_WIDTH-1:0] pwdata,
  output logic                                pready,
  output logic       [`IIR_APB_DATA_WIDTH-1:0] prdata,
  output logic                                y_valid,
  output logic signed [`IIR_N_BITS-1:0]       y
);

  // configuration
  logic                                   enable;
  logic                                   bypass;
  logic                                   clear;
  logic        [`IIR_WAVE_WIDTH-1:0]       step;
  logic        [`IIR_MAX_PERIOD_WIDTH-1:0] period;
  logic signed [`IIR_COEF_WIDTH-1:0]       b0;
  logic signed [`IIR_COEF_WIDTH-1:0]       b1;
  logic signed [`IIR_COEF_WIDTH-1:0]       b2;
  logic signed [`IIR_COEF_WIDTH-1:0]       a1;
  logic signed [`IIR_COEF_WIDTH-1:0]       a2;

  // oscillator to filter link
  logic                                   sample_valid;
  logic signed [`IIR_WAVE_WIDTH-1:0]       sample;
  logic                                   credit_return;
  logic                                   overrun;

  iir_apb_regs iir_apb_regs_i0 (
    .clk     ( clk     ), .rst_n   ( rst_n   ),
    .psel    ( psel    ), .penable ( penable ), .pwrite ( pwrite ),
    .paddr   ( paddr   ), .pwdata  ( pwdata  ),
    .pready  ( pready  ), .prdata  ( prdata  ),
    .overrun ( overrun ),
    .enable  ( enable  ), .bypass  ( bypass  ), .clear  ( clear  ),
    .step    ( step    ), .period  ( period  ),
    .b0      ( b0      ), .b1      ( b1      ), .b2     ( b2     ),
    .a1      ( a1      ), .a2      ( a2      )
  );

  triangle_osc triangle_osc_i0 (
    .clk           ( clk           ), .rst_n  ( rst_n  ),
    .enable        ( enable        ), .clear  ( clear  ),
    .step          ( step          ), .period ( period ),
    .credit_return ( credit_return ),
    .sample_valid  ( sample_valid  ), .sample ( sample ),
    .overrun       ( overrun       )
  );

  biquad_mac biquad_mac_i0 (
    .clk           ( clk           ), .rst_n  ( rst_n  ),
    .clear         ( clear         ), .bypass ( bypass ),
    .b0            ( b0            ), .b1     ( b1     ), .b2 ( b2 ),
    .a1            ( a1            ), .a2     ( a2     ),
    .sample_valid  ( sample_valid  ), .sample ( sample ),
    .credit_return ( credit_return ),
    .y_valid       ( y_valid       ), .y      ( y      )
  );

endmodule

`default_nettype wire

// ==== rtl/biquad_mac.sv ====
//////////////////////////////////////////////////
// direct-form-I biquad, one MAC per cycle, with
// credit-managed input buffer and bypass
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_params.svh"

`default_nettype none

module biquad_mac
  import iir_pkg::*;
(
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               clear,
  input  wire                               bypass,
  input  wire signed [`IIR_COEF_WIDTH-1:0]  b0,
  input  wire signed [`IIR_COEF_WIDTH-1:0]  b1,
  input  wire signed [`IIR_COEF_WIDTH-1:0]  b2,
  input  wire signed [`IIR_COEF_WIDTH-1:0]  a1,
  input  wire signed [`IIR_COEF_WIDTH-1:0]  a2,
  input  wire                               sample_valid,
  input  wire signed [`IIR_WAVE_WIDTH-1:0]  sample,
  output logic                              credit_return,
  output logic                              y_valid,
  output logic signed [`IIR_N_BITS-1:0]     y
);

  localparam int W     = `IIR_WAVE_WIDTH;
  localparam int N     = `IIR_N_BITS;
  localparam int C     = `IIR_COEF_WIDTH;
  localparam int A     = `IIR_ACC_WIDTH;
  localparam int P     = C + N;
  localparam int PTR_W = $clog2(`IIR_CREDITS);
  localparam int CNT_W = $clog2(`IIR_CREDITS + 1);

  logic signed [W-1:0] buf_mem [`IIR_CREDITS];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    buf_cnt;
  logic [CNT_W-1:0]    pend_cnt;                // credits owed after a flush
  logic                pop;
  logic                drain;
  logic signed [N-1:0] head_ext;
  mac_state_t          state;
  logic [2:0]          tap;
  logic signed [N-1:0] x0;
  logic signed [N-1:0] x1;
  logic signed [N-1:0] x2;
  logic signed [N-1:0] y1;
  logic signed [N-1:0] y2;
  logic signed [C-1:0] mul_c;
  logic signed [N-1:0] mul_d;
  logic signed [P-1:0] prod;
  logic signed [A-1:0] prod_ext;
  logic signed [A-1:0] acc;
  logic signed [A-1:0] acc_sh;
  logic signed [N-1:0] y_sat;

  assign pop      = (state == IDLE) && (buf_cnt != '0) && !clear;
  assign drain    = !pop && (pend_cnt != '0);
  assign head_ext = {{(N-W){buf_mem[rd_ptr][W-1]}}, buf_mem[rd_ptr]};

  //////////////////////////////////////////////////
  // input buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sample_valid)
      buf_mem[wr_ptr] <= sample;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      buf_cnt       <= '0;
      pend_cnt      <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop | drain;
      if (clear) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        buf_cnt  <= '0;
        pend_cnt <= pend_cnt - CNT_W'(drain) + buf_cnt + CNT_W'(sample_valid);
      end else begin
        pend_cnt <= pend_cnt - CNT_W'(drain);
        buf_cnt  <= buf_cnt + CNT_W'(sample_valid) - CNT_W'(pop);
        if (sample_valid)
          wr_ptr <= (wr_ptr == PTR_W'(`IIR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
        if (pop)
          rd_ptr <= (rd_ptr == PTR_W'(`IIR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // multiply-accumulate datapath
  //////////////////////////////////////////////////

  always_comb begin
    case (tap)
      3'd0:    begin mul_c = b0; mul_d = x0; end
      3'd1:    begin mul_c = b1; mul_d = x1; end
      3'd2:    begin mul_c = b2; mul_d = x2; end
      3'd3:    begin mul_c = a1; mul_d = y1; end
      default: begin mul_c = a2; mul_d = y2; end
    endcase
  end

  assign prod     = mul_c * mul_d;
  assign prod_ext = {{(A-P){prod[P-1]}}, prod};
  assign acc_sh   = acc >>> `IIR_Q_BITS;          // floor shift

  // saturate to the output width
  always_comb begin
    if (acc_sh[A-1:N-1] == '0 || acc_sh[A-1:N-1] == '1)
      y_sat = acc_sh[N-1:0];
    else if (acc_sh[A-1])
      y_sat = {1'b1, {(N-1){1'b0}}};
    else
      y_sat = {1'b0, {(N-1){1'b1}}};
  end

  always_ff @(posedge clk) begin
    if (pop)
      x0 <= head_ext;
    if (state == ACCUM) begin
      if (tap == 3'd0)
        acc <= prod_ext;
      else if (tap < 3'd3)
        acc <= acc + prod_ext;                    // feed-forward taps
      else
        acc <= acc - prod_ext;                    // feedback taps
    end
  end

  //////////////////////////////////////////////////
  // control FSM and history
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      tap     <= '0;
      x1      <= '0;
      x2      <= '0;
      y1      <= '0;
      y2      <= '0;
      y_valid <= 1'b0;
      y       <= '0;
    end else if (clear) begin
      state   <= IDLE;                            // abandon any sample in flight
      tap     <= '0;
      x1      <= '0;
      x2      <= '0;
      y1      <= '0;
      y2      <= '0;
      y_valid <= 1'b0;
    end else begin
      y_valid <= 1'b0;
      case (state)
        IDLE: begin
          tap <= '0;
          if (pop && bypass) begin
            y       <= head_ext;                  // history untouched
            y_valid <= 1'b1;
          end else if (pop)
            state <= ACCUM;
        end
        ACCUM: begin
          tap <= tap + 1'b1;
          if (tap == 3'd4)
            state <= EMIT;
        end
        EMIT: begin
          y       <= y_sat;
          y_valid <= 1'b1;
          x1      <= x0;
          x2      <= x1;
          y1      <= y_sat;
          y2      <= y1;
          state   <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // oscillator credit accounting keeps the buffer from overflowing
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
      sample_valid |-> (buf_cnt != CNT_W'(`IIR_CREDITS))
  );

endmodule

`default_nettype wire

// ==== rtl/triangle_osc.sv ====
//////////////////////////////////////////////////
// sample tick and triangle test source, sends
// samples to the filter against credits
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_params.svh"

`default_nettype none

module triangle_osc
  import iir_pkg::*;
(
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire                                     enable,
  input  wire                                     clear,
  input  wire        [`IIR_WAVE_WIDTH-1:0]        step,
  input  wire        [`IIR_MAX_PERIOD_WIDTH-1:0]  period,
  input  wire                                     credit_return,
  output logic                                    sample_valid,
  output logic signed [`IIR_WAVE_WIDTH-1:0]       sample,
  output logic                                    overrun
);

  localparam int W      = `IIR_WAVE_WIDTH;
  localparam int CRED_W = $clog2(`IIR_CREDITS + 1);
  localparam logic signed [W-1:0] WAVE_MAX = {1'b0, {(W-1){1'b1}}};
  localparam logic signed [W-1:0] WAVE_MIN = {1'b1, {(W-1){1'b0}}};

  logic [`IIR_MAX_PERIOD_WIDTH-1:0] tick_cnt;
  logic                             tick;
  logic                             send;
  logic [CRED_W-1:0]                credits;
  logic signed [W-1:0]              wave;
  ramp_dir_t                        dir;
  logic signed [W+1:0]              up_sum;    // two guard bits
  logic signed [W+1:0]              dn_sum;

  assign tick   = enable && (period != '0) && (tick_cnt >= period - 1'b1);
  assign send   = tick && (credits != '0);
  assign up_sum = $signed({{2{wave[W-1]}}, wave}) + $signed({2'b00, step});
  assign dn_sum = $signed({{2{wave[W-1]}}, wave}) - $signed({2'b00, step});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt     <= '0;
      credits      <= CRED_W'(`IIR_CREDITS);
      sample_valid <= 1'b0;
      sample       <= '0;
      overrun      <= 1'b0;
      wave         <= '0;
      dir          <= UP;
    end else begin
      if (!enable || tick)
        tick_cnt <= '0;
      else if (period != '0)
        tick_cnt <= tick_cnt + 1'b1;
      credits      <= credits - CRED_W'(send) + CRED_W'(credit_return);
      sample_valid <= send;
      overrun      <= tick && (credits == '0);  // lost tick, wave holds
      if (send)
        sample <= wave;
      if (clear) begin
        wave <= '0;                             // restart at zero, rising
        dir  <= UP;
      end else if (send) begin
        if (dir == UP) begin
          if (up_sum > WAVE_MAX) begin
            wave <= WAVE_MAX;
            dir  <= DOWN;
          end else
            wave <= up_sum[W-1:0];
        end else begin
          if (dn_sum < WAVE_MIN) begin
            wave <= WAVE_MIN;
            dir  <= UP;
          end else
            wave <= dn_sum[W-1:0];
        end
      end
    end
  end

  // filter never returns more credits than were spent
  a_credit_bound : assert property (
    @(posedge clk) disable iff (!rst_n) credits <= CRED_W'(`IIR_CREDITS)
  );

endmodule

`default_nettype wire

// ==== rtl/iir_apb_regs.sv ====
//////////////////////////////////////////////////
// APB3 register block: control, oscillator setup,
// Q2.14 coefficients and sticky overrun status
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_params.svh"

`default_nettype none

module iir_apb_regs
  import iir_pkg::*;
(
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire                                     psel,
  input  wire                                     penable,
  input  wire                                     pwrite,
  input  wire        [`IIR_APB_ADDR_WIDTH-1:0]    paddr,
  input  wire        [`IIR_APB_DATA_WIDTH-1:0]    pwdata,
  output logic                                    pready,
  output logic       [`IIR_APB_DATA_WIDTH-1:0]    prdata,
  input  wire                                     overrun,
  output logic                                    enable,
  output logic                                    bypass,
  output logic                                    clear,
  output logic       [`IIR_WAVE_WIDTH-1:0]        step,
  output logic       [`IIR_MAX_PERIOD_WIDTH-1:0]  period,
  output logic signed [`IIR_COEF_WIDTH-1:0]       b0,
  output logic signed [`IIR_COEF_WIDTH-1:0]       b1,
  output logic signed [`IIR_COEF_WIDTH-1:0]       b2,
  output logic signed [`IIR_COEF_WIDTH-1:0]       a1,
  output logic signed [`IIR_COEF_WIDTH-1:0]       a2
);

  localparam int C = `IIR_COEF_WIDTH;

  reg_addr_t addr;
  logic      wr_en;
  logic      en_next;
  logic      ovr_flag;

  assign pready  = 1'b1;                 // no wait states
  assign addr    = reg_addr_t'(paddr);
  assign wr_en   = psel & penable & pwrite;
  assign en_next = (wr_en && addr == CTRL) ? pwdata[0] : enable;

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable   <= 1'b0;
      bypass   <= 1'b0;
      clear    <= 1'b0;
      step     <= '0;
      period   <= '0;
      b0       <= '0;
      b1       <= '0;
      b2       <= '0;
      a1       <= '0;
      a2       <= '0;
      ovr_flag <= 1'b0;
    end else begin
      clear <= wr_en & ~en_next;         // one cycle, flushes the pipeline
      if (wr_en) begin
        case (addr)
          CTRL: begin
            enable <= pwdata[0];
            bypass <= pwdata[1];
          end
          STEP:    step   <= pwdata[`IIR_WAVE_WIDTH-1:0];
          PERIOD:  period <= pwdata[`IIR_MAX_PERIOD_WIDTH-1:0];
          B0:      b0     <= $signed(pwdata[C-1:0]);
          B1:      b1     <= $signed(pwdata[C-1:0]);
          B2:      b2     <= $signed(pwdata[C-1:0]);
          A1:      a1     <= $signed(pwdata[C-1:0]);
          A2:      a2     <= $signed(pwdata[C-1:0]);
          default: ;
        endcase
      end
      // a new overrun wins over a clearing write
      if (overrun)
        ovr_flag <= 1'b1;
      else if (wr_en && addr == STATUS)
        ovr_flag <= 1'b0;
    end
  end

  // readback, zero for unmapped addresses
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (addr)
        CTRL:    prdata[1:0] = {bypass, enable};
        STEP:    prdata[`IIR_WAVE_WIDTH-1:0] = step;
        PERIOD:  prdata[`IIR_MAX_PERIOD_WIDTH-1:0] = period;
        B0:      prdata[C-1:0] = b0;
        B1:      prdata[C-1:0] = b1;
        B2:      prdata[C-1:0] = b2;
        A1:      prdata[C-1:0] = a1;
        A2:      prdata[C-1:0] = a2;
        STATUS:  prdata[0] = ovr_flag;
        default: prdata = '0;
      endcase
    end
  end

  // access phase is always preceded by a selected setup phase
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  );

endmodule

`default_nettype wire

// ==== rtl/iir_pkg.sv ====
//////////////////////////////////////////////////
// shared enums for the biquad test system
//////////////////////////////////////////////////

`include "iir_params.svh"

package iir_pkg;

  // APB register map
  typedef enum logic [`IIR_APB_ADDR_WIDTH-1:0] {
    CTRL   = `IIR_ADDR_CTRL,   // bit 0 enable, bit 1 bypass
    STEP   = `IIR_ADDR_STEP,
    PERIOD = `IIR_ADDR_PERIOD,
    B0     = `IIR_ADDR_B0,
    B1     = `IIR_ADDR_B1,
    B2     = `IIR_ADDR_B2,
    A1     = `IIR_ADDR_A1,
    A2     = `IIR_ADDR_A2,
    STATUS = `IIR_ADDR_STATUS  // bit 0 sticky overrun
  } reg_addr_t;

  // sequential MAC phases
  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    EMIT
  } mac_state_t;

  typedef enum logic {
    UP,
    DOWN
  } ramp_dir_t;

endpackage

// ==== include/iir_params.svh ====
//////////////////////////////////////////////////
// biquad test system widths, credit count and
// APB register map
//////////////////////////////////////////////////

`ifndef IIR_PARAMS_SVH
`define IIR_PARAMS_SVH

// datapath widths
`define IIR_WAVE_WIDTH        12
`define IIR_N_BITS            16
`define IIR_Q_BITS            14
`define IIR_COEF_WIDTH        16
`define IIR_ACC_WIDTH         40
`define IIR_MAX_PERIOD_WIDTH  16

// APB bus
`define IIR_APB_ADDR_WIDTH    8
`define IIR_APB_DATA_WIDTH    32

// filter input buffer depth, also the starting credit count
`define IIR_CREDITS           2

// register byte addresses
`define IIR_ADDR_CTRL         8'h00
`define IIR_ADDR_STEP         8'h04
`define IIR_ADDR_PERIOD       8'h08
`define IIR_ADDR_B0           8'h0C
`define IIR_ADDR_B1           8'h10
`define IIR_ADDR_B2           8'h14
`define IIR_ADDR_A1           8'h18
`define IIR_ADDR_A2           8'h1C
`define IIR_ADDR_STATUS       8'h20

`endif
